// File: design/adder_pkg.sv
// Serial adder datapath definitions

package adder_pkg;

    //--------------------------------------------------------------------------
    // Datapath sizes
    //--------------------------------------------------------------------------

    // Bits kept per lane, enough for one hex digit
    localparam int history_depth = 4;

    // LEDs on the lab board
    localparam int led_width = 8;

    //--------------------------------------------------------------------------
    // Adder state
    //--------------------------------------------------------------------------

    // The carry is the only state the serial adder keeps
    typedef enum logic {
        carry_clear = 1'b0,
        carry_set   = 1'b1
    } carry_state_t;

endpackage

// File: design/display_pkg.sv
// Seven-segment display definitions

package display_pkg;

    //--------------------------------------------------------------------------
    // Scan geometry
    //--------------------------------------------------------------------------

    localparam int digit_count = 8;

    // Short dwell so the scan is visible in simulation
    localparam int scan_cycles = 4;

    localparam int pos_width  = $clog2(digit_count);
    localparam int scan_width = $clog2(scan_cycles);

    // Terminal counts for the position and dwell counters
    localparam logic [pos_width-1:0]  pos_last  = pos_width'(digit_count - 1);
    localparam logic [scan_width-1:0] scan_last = scan_width'(scan_cycles - 1);

    // Display positions that carry a history lane
    typedef enum logic [pos_width-1:0] {
        slot_a   = 0,
        slot_b   = 1,
        slot_sum = 2
    } digit_slot_t;

    //--------------------------------------------------------------------------
    // Segment encoding, bit 7 is segment a and bit 0 the dot
    //--------------------------------------------------------------------------

    function automatic logic [7:0] hex_to_segments(input logic [3:0] value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

// File: design/serial_bus_if.sv
// Serial step bus

`timescale 1ns/100ps

interface serial_bus_if;

    // One bit triple per step
    logic a;
    logic b;
    logic sum;

    // Single-cycle pulses, never high together
    logic valid;
    logic clear;

    modport producer (
        output a,
        output b,
        output sum,
        output valid,
        output clear
    );

    modport consumer (
        input a,
        input b,
        input sum,
        input valid,
        input clear
    );

endinterface

// File: design/serial_adder.sv
// Bit-serial adder stage

`timescale 1ns/100ps

module serial_adder (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            a,
    input  logic            b,
    input  logic            step,
    input  logic            clear,
    serial_bus_if.producer  bus
);

    adder_pkg::carry_state_t carry;

    logic carry_in;
    logic sum_bit;
    logic carry_out;

    logic a_q;
    logic b_q;
    logic sum_q;
    logic valid_q;
    logic clear_q;

    //--------------------------------------------------------------------------
    // Full adder on the current bit pair
    //--------------------------------------------------------------------------

    assign carry_in  = (carry == adder_pkg::carry_set);
    assign sum_bit   = a ^ b ^ carry_in;
    // Majority of the three inputs
    assign carry_out = (a & b) | (a & carry_in) | (b & carry_in);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carry   <= adder_pkg::carry_clear;
            a_q     <= 1'b0;
            b_q     <= 1'b0;
            sum_q   <= 1'b0;
            valid_q <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            valid_q <= step;
            clear_q <= clear;
            if (clear) begin
                carry <= adder_pkg::carry_clear;
            end else if (step) begin
                a_q   <= a;
                b_q   <= b;
                sum_q <= sum_bit;
                carry <= carry_out ? adder_pkg::carry_set : adder_pkg::carry_clear;
            end
        end
    end

    // Registered triple goes out with the pulse one cycle after step
    assign bus.a     = a_q;
    assign bus.b     = b_q;
    assign bus.sum   = sum_q;
    assign bus.valid = valid_q;
    assign bus.clear = clear_q;

endmodule

// File: design/bit_history.sv
// Bit history shift registers

`timescale 1ns/100ps

module bit_history (
    input  logic                                  clk,
    input  logic                                  rst_n,
    serial_bus_if.consumer                        bus,
    output logic [adder_pkg::history_depth-1:0]   a_bits,
    output logic [adder_pkg::history_depth-1:0]   b_bits,
    output logic [adder_pkg::history_depth-1:0]   sum_bits
);

    localparam int lane_count = 3;

    // Lane 0 is a, lane 1 is b, lane 2 is sum
    logic [adder_pkg::history_depth-1:0] lanes [lane_count];
    logic [lane_count-1:0]               new_bits;

    assign new_bits = {bus.sum, bus.b, bus.a};

    //--------------------------------------------------------------------------
    // Shift right on valid, newest bit enters at the top
    //--------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < lane_count; i++) begin
                lanes[i] <= '0;
            end
        end else if (bus.clear) begin
            // New word starts from an empty history
            for (int i = 0; i < lane_count; i++) begin
                lanes[i] <= '0;
            end
        end else if (bus.valid) begin
            for (int i = 0; i < lane_count; i++) begin
                lanes[i] <= {new_bits[i], lanes[i][adder_pkg::history_depth-1:1]};
            end
        end
    end

    // After four steps the earliest bit sits at bit 0
    assign a_bits   = lanes[0];
    assign b_bits   = lanes[1];
    assign sum_bits = lanes[2];

endmodule

// File: design/seven_segment_scan.sv
// Multiplexed seven-segment scan

`timescale 1ns/100ps

module seven_segment_scan (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [adder_pkg::history_depth-1:0]   a_bits,
    input  logic [adder_pkg::history_depth-1:0]   b_bits,
    input  logic [adder_pkg::history_depth-1:0]   sum_bits,
    output logic [7:0]                            abcdefgh,
    output logic [display_pkg::digit_count-1:0]   digit
);

    logic [display_pkg::scan_width-1:0]   scan_cnt;
    logic                                 scan_wrap;
    logic [display_pkg::pos_width-1:0]    pos;
    logic [display_pkg::pos_width-1:0]    pos_next;

    logic [adder_pkg::history_depth-1:0]  hex_value;
    logic                                 hex_shown;
    logic [7:0]                           segments_next;
    logic [display_pkg::digit_count-1:0]  digit_next;

    //--------------------------------------------------------------------------
    // Dwell and position counters
    //--------------------------------------------------------------------------

    always_comb begin
        scan_wrap = (scan_cnt == display_pkg::scan_last);
        pos_next  = pos;
        if (scan_wrap) begin
            pos_next = (pos == display_pkg::pos_last) ? '0 : pos + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            pos      <= '0;
        end else begin
            scan_cnt <= scan_wrap ? '0 : scan_cnt + 1'b1;
            pos      <= pos_next;
        end
    end

    //--------------------------------------------------------------------------
    // Lane select and blanking
    //--------------------------------------------------------------------------

    always_comb begin
        hex_value = '0;
        hex_shown = 1'b1;
        case (display_pkg::digit_slot_t'(pos_next))
            display_pkg::slot_a:   hex_value = a_bits;
            display_pkg::slot_b:   hex_value = b_bits;
            display_pkg::slot_sum: hex_value = sum_bits;
            // Positions above the three lanes stay dark
            default:               hex_shown = 1'b0;
        endcase
    end

    assign segments_next = hex_shown ? display_pkg::hex_to_segments(hex_value) : '0;

    always_comb begin
        digit_next           = '0;
        digit_next[pos_next] = 1'b1;
    end

    //--------------------------------------------------------------------------
    // Output registers
    //--------------------------------------------------------------------------

    // Both driven from pos_next so segments and digit always match pos
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit    <= {{(display_pkg::digit_count - 1){1'b0}}, 1'b1};
            abcdefgh <= display_pkg::hex_to_segments(4'h0);
        end else begin
            digit    <= digit_next;
            abcdefgh <= segments_next;
        end
    end

endmodule

// File: design/serial_adder_top.sv
// Serial adder board top

`timescale 1ns/100ps

module serial_adder_top (
    input  logic                                clk,
    input  logic                                rst_n,

    // Keys and strobes
    input  logic [3:0]                          key,
    input  logic                                step,
    input  logic                                clear,

    // LEDs and the multiplexed display
    output logic [adder_pkg::led_width-1:0]     led,
    output logic [7:0]                          abcdefgh,
    output logic [display_pkg::digit_count-1:0] digit
);

    //--------------------------------------------------------------------------
    // Stage 1, serial adder
    //--------------------------------------------------------------------------

    serial_bus_if bus ();

    // key[0] is operand a, key[1] is operand b
    serial_adder i_adder (
        .clk   ( clk    ),
        .rst_n ( rst_n  ),
        .a     ( key[0] ),
        .b     ( key[1] ),
        .step  ( step   ),
        .clear ( clear  ),
        .bus   ( bus    )
    );

    // Latest triple on the low LEDs
    assign led = {{(adder_pkg::led_width - 3){1'b0}}, bus.sum, bus.b, bus.a};

    //--------------------------------------------------------------------------
    // Stage 2, histories
    //--------------------------------------------------------------------------

    logic [adder_pkg::history_depth-1:0] a_bits;
    logic [adder_pkg::history_depth-1:0] b_bits;
    logic [adder_pkg::history_depth-1:0] sum_bits;

    bit_history i_history (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .bus      ( bus      ),
        .a_bits   ( a_bits   ),
        .b_bits   ( b_bits   ),
        .sum_bits ( sum_bits )
    );

    //--------------------------------------------------------------------------
    // Stage 3, display scan
    //--------------------------------------------------------------------------

    seven_segment_scan i_display (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .a_bits   ( a_bits   ),
        .b_bits   ( b_bits   ),
        .sum_bits ( sum_bits ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// File: dv/tb_serial_adder.sv
// Serial adder testbench

`timescale 1ns/100ps

module tb_serial_adder;

    localparam int max_rows = 64;

    // DUT inputs start low, reset asserted
    logic                                clk   = 1'b0;
    logic                                rst_n = 1'b0;
    logic [3:0]                          key   = 4'b0000;
    logic                                step  = 1'b0;
    logic                                clear = 1'b0;
    logic [adder_pkg::led_width-1:0]     led;
    logic [7:0]                          abcdefgh;
    logic [display_pkg::digit_count-1:0] digit;

    // Row word, one hex digit per field
    logic [27:0] stim_mem [max_rows];
    int          row_count   = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          errors      = 0;
    int          checks      = 0;
    logic        checking    = 1'b0;

    // Expected outputs, and pending updates tagged with the cycle they show up
    logic [adder_pkg::led_width-1:0] led_exp  = '0;
    logic [11:0]                     hist_exp = '0;
    int                              led_due [$];
    logic [2:0]                      led_val [$];
    int                              hist_due [$];
    logic [11:0]                     hist_val [$];

    // Scan tracking
    int         pos_now     = 0;
    int         pos_last    = 0;
    int         dwell       = 0;
    logic       dwell_known = 1'b0;
    int         wraps       = 0;
    logic [7:0] seg_exp;

    serial_adder_top dut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .step     ( step     ),
        .clear    ( clear    ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // Segments a..g on bits 7..1, dot on bit 0
    function automatic logic [7:0] seg_pattern(input logic [3:0] value);
        case (value)
            4'h0:    return 8'hfc;
            4'h1:    return 8'h60;
            4'h2:    return 8'hda;
            4'h3:    return 8'hf2;
            4'h4:    return 8'h66;
            4'h5:    return 8'hb6;
            4'h6:    return 8'hbe;
            4'h7:    return 8'he0;
            4'h8:    return 8'hfe;
            4'h9:    return 8'hf6;
            4'ha:    return 8'hee;
            4'hb:    return 8'h3e;
            4'hc:    return 8'h9c;
            4'hd:    return 8'h7a;
            4'he:    return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Output monitor, samples on the falling edge
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (checking) begin
            while (led_due.size() > 0 && led_due[0] <= cycles) begin
                led_exp      = '0;
                led_exp[2:0] = led_val[0];
                led_due.delete(0);
                led_val.delete(0);
            end
            while (hist_due.size() > 0 && hist_due[0] <= cycles) begin
                hist_exp = hist_val[0];
                hist_due.delete(0);
                hist_val.delete(0);
            end
            checks++;
            if (led !== led_exp) begin
                errors++;
                $display("Error at %0t: led expected %h, got %h", $time, led_exp, led);
            end
            if ($countones(digit) != 1) begin
                errors++;
                $display("Error at %0t: digit is not one-hot, got %b", $time, digit);
            end else begin
                for (int i = 0; i < display_pkg::digit_count; i++) begin
                    if (digit[i]) pos_now = i;
                end
                if (pos_now == pos_last) begin
                    dwell++;
                end else begin
                    if (pos_now != (pos_last + 1) % display_pkg::digit_count) begin
                        errors++;
                        $display("Error at %0t: digit position expected %0d, got %0d",
                                 $time, (pos_last + 1) % display_pkg::digit_count, pos_now);
                    end
                    if (dwell_known && dwell != display_pkg::scan_cycles) begin
                        errors++;
                        $display("Error at %0t: digit dwell expected %0d, got %0d",
                                 $time, display_pkg::scan_cycles, dwell);
                    end
                    if (pos_now == 0) wraps++;
                    dwell_known = 1'b1;
                    dwell       = 1;
                    pos_last    = pos_now;
                end
                case (pos_now)
                    0:       seg_exp = seg_pattern(hist_exp[11:8]);
                    1:       seg_exp = seg_pattern(hist_exp[7:4]);
                    2:       seg_exp = seg_pattern(hist_exp[3:0]);
                    default: seg_exp = 8'h00;
                endcase
                if (abcdefgh !== seg_exp) begin
                    errors++;
                    $display("Error at %0t: abcdefgh at position %0d expected %h, got %h",
                             $time, pos_now, seg_exp, abcdefgh);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------------------

    initial begin
        int          gap;
        int          k;
        int          start_wraps;
        int          steps_since_clear;
        logic [27:0] row;
        logic        row_a;
        logic        row_b;
        logic        row_clear;
        logic        carry_m;
        logic        sum_m;
        logic [3:0]  a_m;
        logic [3:0]  b_m;
        logic [3:0]  s_m;

        void'($urandom(20));
        for (int i = 0; i < max_rows; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh("dv/serial_adder_stim.txt", stim_mem);
        while (row_count < max_rows && stim_mem[row_count] != '1) begin
            row_count++;
        end
        if (row_count == 0) begin
            errors++;
            $display("No stimulus rows could be read from the stimulus file");
        end
        cycle_limit = (row_count * (4 + 3)
                       + 3 * display_pkg::digit_count * display_pkg::scan_cycles) * 2;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        checking = 1'b1;

        // One full scan of the reset state
        while (wraps < 1) @(posedge clk);

        carry_m           = 1'b0;
        sum_m             = 1'b0;
        a_m               = '0;
        b_m               = '0;
        s_m               = '0;
        steps_since_clear = 0;
        for (int r = 0; r < row_count; r++) begin
            row       = stim_mem[r];
            row_a     = row[24];
            row_b     = row[20];
            row_clear = row[16];
            @(posedge clk);
            k = cycles;
            key   <= {2'b00, row_b, row_a};
            step  <= ~row_clear;
            clear <= row_clear;
            if (row_clear) begin
                carry_m           = 1'b0;
                sum_m             = 1'b0;
                a_m               = '0;
                b_m               = '0;
                s_m               = '0;
                steps_since_clear = 0;
            end else begin
                sum_m   = row_a ^ row_b ^ carry_m;
                carry_m = (row_a & row_b) | (row_a & carry_m) | (row_b & carry_m);
                a_m     = {row_a, a_m[3:1]};
                b_m     = {row_b, b_m[3:1]};
                s_m     = {sum_m, s_m[3:1]};
                steps_since_clear++;
                // LEDs follow one edge after the DUT samples step
                led_due.push_back(k + 2);
                led_val.push_back({sum_m, row_b, row_a});
            end
            // Display registers follow three edges after the sampling edge
            hist_due.push_back(k + 4);
            if (steps_since_clear == 4) begin
                // A whole word since the clear, so the sum lane is the word sum
                hist_val.push_back({a_m, b_m, 4'(a_m + b_m)});
            end else begin
                hist_val.push_back({a_m, b_m, s_m});
            end
            if (row[15:0] != {3'b000, sum_m, a_m, b_m, s_m}) begin
                errors++;
                $display("Stimulus row %0d disagrees with the adder rules: file %h, model %h",
                         r, row[15:0], {3'b000, sum_m, a_m, b_m, s_m});
            end
            gap = int'($urandom % 4);
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                step  <= 1'b0;
                clear <= 1'b0;
            end
        end
        @(posedge clk);
        step  <= 1'b0;
        clear <= 1'b0;

        // Let the last histories settle, then watch one complete scan
        while (hist_due.size() != 0) @(posedge clk);
        start_wraps = wraps;
        while (wraps < start_wraps + 2) @(posedge clk);

        $display("Run complete: %0d rows, %0d checks, %0d errors", row_count, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        @(posedge clk);
        while (cycles < cycle_limit) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles: %0d checks, %0d errors", cycle_limit, checks, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: dv/serial_adder_stim.txt
// One row per step or clear, hex digits left to right:
// a, b, clear, expected sum, expected a_bits, expected b_bits, expected sum_bits
0010000
1100880
01004C0
1000A60
0001538
1100A94
0010000
1100880
1000C40
1000E20
1000F10
0001708
0010000
0101088
11008C4
1101CEA
000167D
0010000
1100880
01004C0
0001268
11009B4
0010000
1001808
1100C84
1101ECA
01007E5

// File: verilog.f
design/adder_pkg.sv
design/display_pkg.sv
design/serial_bus_if.sv
design/serial_adder.sv
design/bit_history.sv
design/seven_segment_scan.sv
design/serial_adder_top.sv
dv/tb_serial_adder.sv

// File: Makefile
# Verilator build and run for the serial adder testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_adder
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the testbench prints the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
